/* source/vec_beat_counter.sv */
module vec_beat_counter (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        start_i,
  input  logic [vec_pkg::BEAT_W:0]    count_i,
  output logic [vec_pkg::BEAT_W-1:0]  beat_o,
  output logic                        active_o,
  output logic                        last_o
);
  import vec_pkg::*;

  logic [BEAT_W:0]   remaining_q;
  logic [BEAT_W-1:0] beat_q;
  logic              active_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      remaining_q <= '0;
      beat_q      <= '0;
      active_q    <= 1'b0;
    end else if (start_i && count_i != '0) begin
      remaining_q <= count_i;
      beat_q      <= '0;
      active_q    <= 1'b1;
    end else if (active_q) begin
      if (last_o) begin
        active_q <= 1'b0;
      end else begin
        remaining_q <= remaining_q - 1'b1;
        beat_q      <= beat_q + 1'b1;
      end
    end
  end

  assign beat_o   = beat_q;
  assign active_o = active_q;
  // Final beat when only one remains
  assign last_o   = active_q && (remaining_q == (BEAT_W + 1)'(1));

endmodule

/* source/vec_dispatcher.sv */
module vec_dispatcher (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Host request channel
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  vec_pkg::vec_op_e                req_op_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vd_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vs1_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vs2_i,
  input  logic [vec_pkg::ELEM_W-1:0]      req_scalar_i,
  // Host response channel
  output logic                            resp_valid_o,
  input  logic                            resp_ready_i,
  output logic [vec_pkg::ELEM_W-1:0]      resp_data_o,
  output logic                            resp_err_o,
  // Beat counter
  output logic                            beat_start_o,
  output logic [vec_pkg::BEAT_W:0]        beat_count_o,
  input  logic                            beat_active_i,
  input  logic                            beat_last_i,
  // Lanes
  output vec_pkg::vec_op_e                op_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]  vd_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]  vs1_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]  vs2_o,
  output logic [vec_pkg::ELEM_W-1:0]      scalar_o,
  output logic [vec_pkg::VL_W-1:0]        vl_o,
  output logic [vec_pkg::BEAT_W-1:0]      ext_row_o,
  input  logic [vec_pkg::ELEM_W-1:0]      ext_data_i
);
  import vec_pkg::*;

  disp_state_e             state_q, state_d;
  vec_op_e                 op_q;
  logic [VREG_IDX_W-1:0]   vd_q, vs1_q, vs2_q;
  logic [ELEM_W-1:0]       scalar_q;
  logic [VL_W-1:0]         vl_q;
  logic [ELEM_W-1:0]       resp_data_q;
  logic                    resp_err_q;

  logic                    accept;
  logic                    is_vec_op;
  logic                    is_illegal;
  logic                    ext_oob;
  logic [VL_W-1:0]         new_vl;
  logic [VL_W-1:0]         vl_round;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  assign accept = req_valid_i && req_ready_o;

  always_comb begin
    is_vec_op  = 1'b0;
    is_illegal = 1'b0;
    case (req_op_i)
      VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV, VADD_VX, VMV_V_X, VID_V: begin
        is_vec_op = 1'b1;
      end
      VSETVL, VEXT_X_V: begin
        is_vec_op = 1'b0;
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

  assign ext_oob = (req_op_i == VEXT_X_V) && (req_scalar_i >= ELEM_W'(VLMAX));
  assign new_vl  = (req_scalar_i > ELEM_W'(VLMAX)) ? VL_W'(VLMAX) : req_scalar_i[VL_W-1:0];

  // ceil(vl / NR_LANES)
  assign vl_round     = vl_q + VL_W'(NR_LANES - 1);
  assign beat_count_o = (BEAT_W + 1)'(vl_round >> LANE_W);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    beat_start_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          if (is_vec_op && beat_count_o != '0) begin
            beat_start_o = 1'b1;
            state_d      = EXEC;
          end else if (req_op_i == VEXT_X_V && !ext_oob) begin
            state_d = READ;
          end else begin
            state_d = RESP;
          end
        end
      end
      EXEC: begin
        if (beat_active_i && beat_last_i) begin
          state_d = RESP;
        end
      end
      READ: begin
        state_d = RESP;
      end
      default: begin
        if (resp_ready_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      vl_q    <= '0;
    end else begin
      state_q <= state_d;
      if (accept && req_op_i == VSETVL) begin
        vl_q <= new_vl;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= req_op_i;
      vd_q        <= req_vd_i;
      vs1_q       <= req_vs1_i;
      vs2_q       <= req_vs2_i;
      scalar_q    <= req_scalar_i;
      resp_data_q <= (req_op_i == VSETVL) ? ELEM_W'(new_vl) : '0;
      resp_err_q  <= is_illegal || ext_oob;
    end else if (state_q == READ) begin
      resp_data_q <= ext_data_i;
    end
  end

  assign req_ready_o  = (state_q == IDLE);
  assign resp_valid_o = (state_q == RESP);
  assign resp_data_o  = resp_data_q;
  assign resp_err_o   = resp_err_q;

  assign op_o      = op_q;
  assign vd_o      = vd_q;
  assign vs1_o     = vs1_q;
  assign vs2_o     = vs2_q;
  assign scalar_o  = scalar_q;
  assign vl_o      = vl_q;
  // Extract index split into row and lane
  assign ext_row_o = scalar_q[LANE_W +: BEAT_W];

endmodule

/* source/vec_lane.sv */
module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  vec_pkg::vec_op_e                op_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  vd_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  vs1_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  vs2_i,
  input  logic [vec_pkg::ELEM_W-1:0]      scalar_i,
  input  logic [vec_pkg::VL_W-1:0]        vl_i,
  input  logic [vec_pkg::BEAT_W-1:0]      beat_i,
  input  logic                            active_i,
  input  logic [vec_pkg::BEAT_W-1:0]      read_row_i,
  output logic [vec_pkg::ELEM_W-1:0]      read_data_o
);
  import vec_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////////////////////////////////////////

  // Row r of register v holds element r * NR_LANES + LANE_ID
  logic [ELEM_W-1:0] vrf [NR_VREGS][ROWS_PER_LANE];

  logic [ELEM_W-1:0] vs1_data;
  logic [ELEM_W-1:0] vs2_data;
  logic [ELEM_W-1:0] alu_res;
  logic [VL_W-1:0]   elem_idx;
  logic              wr_en;

  // vs1 follows the beat, vs2 follows the shared read row
  assign vs1_data    = vrf[vs1_i][beat_i];
  assign vs2_data    = vrf[vs2_i][read_row_i];
  assign read_data_o = vs2_data;

  assign elem_idx = VL_W'(beat_i) * VL_W'(NR_LANES) + VL_W'(LANE_ID);

  ////////////////////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      VADD_VV: begin
        alu_res = vs2_data + vs1_data;
      end
      VSUB_VV: begin
        // vd = vs2 - vs1
        alu_res = vs2_data - vs1_data;
      end
      VAND_VV: begin
        alu_res = vs2_data & vs1_data;
      end
      VOR_VV: begin
        alu_res = vs2_data | vs1_data;
      end
      VXOR_VV: begin
        alu_res = vs2_data ^ vs1_data;
      end
      VADD_VX: begin
        alu_res = vs2_data + scalar_i;
      end
      VMV_V_X: begin
        alu_res = scalar_i;
      end
      VID_V: begin
        alu_res = ELEM_W'(elem_idx);
      end
      default: begin
        alu_res = vs2_data;
      end
    endcase
  end

  // Tail elements at or above vl stay untouched
  assign wr_en = active_i && !rst_i && (elem_idx < vl_i);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      vrf[vd_i][beat_i] <= alu_res;
    end
  end

endmodule

/* source/vec_pkg.sv */
package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES      = 4;
  localparam int unsigned ROWS_PER_LANE = 4;
  localparam int unsigned VLMAX         = NR_LANES * ROWS_PER_LANE;
  localparam int unsigned ELEM_W        = 32;
  localparam int unsigned NR_VREGS      = 8;

  // Derived widths
  localparam int unsigned VREG_IDX_W = $clog2(NR_VREGS);
  localparam int unsigned VL_W       = $clog2(VLMAX + 1);
  localparam int unsigned BEAT_W     = $clog2(ROWS_PER_LANE);
  localparam int unsigned LANE_W     = $clog2(NR_LANES);

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and dispatcher states
  ////////////////////////////////////////////////////////////////////////////

  // Codes 4'ha to 4'hf are illegal
  typedef enum logic [3:0] {
    VSETVL   = 4'h0,
    VADD_VV  = 4'h1,
    VSUB_VV  = 4'h2,
    VAND_VV  = 4'h3,
    VOR_VV   = 4'h4,
    VXOR_VV  = 4'h5,
    VADD_VX  = 4'h6,
    VMV_V_X  = 4'h7,
    VID_V    = 4'h8,
    VEXT_X_V = 4'h9
  } vec_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    EXEC = 2'd1,
    READ = 2'd2,
    RESP = 2'd3
  } disp_state_e;

endpackage

/* source/vec_unit.sv */
module vec_unit (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  vec_pkg::vec_op_e                req_op_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vd_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vs1_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0]  req_vs2_i,
  input  logic [vec_pkg::ELEM_W-1:0]      req_scalar_i,
  output logic                            resp_valid_o,
  input  logic                            resp_ready_i,
  output logic [vec_pkg::ELEM_W-1:0]      resp_data_o,
  output logic                            resp_err_o
);
  import vec_pkg::*;

  logic                  beat_start;
  logic [BEAT_W:0]       beat_count;
  logic [BEAT_W-1:0]     beat;
  logic                  beat_active;
  logic                  beat_last;
  vec_op_e               op;
  logic [VREG_IDX_W-1:0] vd, vs1, vs2;
  logic [ELEM_W-1:0]     scalar;
  logic [VL_W-1:0]       vl;
  logic [BEAT_W-1:0]     ext_row;
  logic [ELEM_W-1:0]     ext_data;
  logic [BEAT_W-1:0]     lane_row;
  logic [ELEM_W-1:0]     lane_rdata [NR_LANES];

  vec_dispatcher u_dispatcher (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_vd_i      (req_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_scalar_i  (req_scalar_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_data_o   (resp_data_o),
    .resp_err_o    (resp_err_o),
    .beat_start_o  (beat_start),
    .beat_count_o  (beat_count),
    .beat_active_i (beat_active),
    .beat_last_i   (beat_last),
    .op_o          (op),
    .vd_o          (vd),
    .vs1_o         (vs1),
    .vs2_o         (vs2),
    .scalar_o      (scalar),
    .vl_o          (vl),
    .ext_row_o     (ext_row),
    .ext_data_i    (ext_data)
  );

  vec_beat_counter u_counter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (beat_start),
    .count_i  (beat_count),
    .beat_o   (beat),
    .active_o (beat_active),
    .last_o   (beat_last)
  );

  // vs2 row follows the beat while executing, the extract row otherwise
  assign lane_row = beat_active ? beat : ext_row;

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) u_lane (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .op_i        (op),
      .vd_i        (vd),
      .vs1_i       (vs1),
      .vs2_i       (vs2),
      .scalar_i    (scalar),
      .vl_i        (vl),
      .beat_i      (beat),
      .active_i    (beat_active),
      .read_row_i  (lane_row),
      .read_data_o (lane_rdata[l])
    );
  end

  // Lane picked by the low bits of the extract index
  assign ext_data = lane_rdata[scalar[LANE_W-1:0]];

endmodule

/* tb/vec_unit_props.sv */
module vec_unit_props (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        req_valid_i,
  input logic                        req_ready_o,
  input logic                        resp_valid_o,
  input logic                        resp_ready_i,
  input logic [vec_pkg::ELEM_W-1:0]  resp_data_o,
  input logic                        resp_err_o,
  input logic [vec_pkg::VL_W-1:0]    vl_o
);
  import vec_pkg::*;

  int unsigned fail_count;

  initial begin
    fail_count = 0;
  end

  // Response stays put until the host takes it
  resp_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_data_o) && $stable(resp_err_o))
    else begin
      $error("response changed before it was accepted");
      fail_count++;
    end

  // An accepted request closes the request channel
  req_taken_a : assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else begin
      $error("req_ready stayed high after a request was taken");
      fail_count++;
    end

  // Request channel reopens only after a response handshake
  one_in_flight_a : assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(req_ready_o) |-> $past(resp_valid_o && resp_ready_i))
    else begin
      $error("req_ready rose without a response handshake");
      fail_count++;
    end

  vl_range_a : assert property (@(posedge clk_i) disable iff (rst_i)
    vl_o <= VL_W'(VLMAX))
    else begin
      $error("vl above VLMAX");
      fail_count++;
    end

endmodule

bind vec_dispatcher vec_unit_props u_props (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_valid_i  (req_valid_i),
  .req_ready_o  (req_ready_o),
  .resp_valid_o (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_data_o  (resp_data_o),
  .resp_err_o   (resp_err_o),
  .vl_o         (vl_o)
);

/* tb/vec_unit_tb.sv */
module vec_unit_tb;
  import vec_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned NUM_TESTS  = 5;
  localparam int unsigned TIMEOUT    = NUM_TESTS * 200 * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  vec_op_e               req_op;
  logic [VREG_IDX_W-1:0] req_vd, req_vs1, req_vs2;
  logic [ELEM_W-1:0]     req_scalar;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [ELEM_W-1:0]     resp_data;
  logic                  resp_err;

  // Reference copy of the register file and vl
  logic [ELEM_W-1:0]     model_vrf [NR_VREGS][VLMAX];
  int unsigned           model_vl;
  logic [31:0]           lcg_state;

  vec_unit uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_op_i     (req_op),
    .req_vd_i     (req_vd),
    .req_vs1_i    (req_vs1),
    .req_vs2_i    (req_vs2),
    .req_scalar_i (req_scalar),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_data_o  (resp_data),
    .resp_err_o   (resp_err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("Error: simulation timed out waiting for the DUT");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wait (uut.u_dispatcher.u_props.fail_count != 0);
    $display("Error: a handshake or vl assertion on the dispatcher failed");
    $display("Some tests failed");
    $fatal(1, "assertion failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s (got %h, expected %h)", $time, msg, actual,
               expected);
      $display("Some tests failed");
      $fatal(1, "check failed");
    end
  endtask

  // One request, then the response after hold cycles of back-pressure
  task automatic issue(input vec_op_e op, input logic [VREG_IDX_W-1:0] vd,
                       input logic [VREG_IDX_W-1:0] vs1, input logic [VREG_IDX_W-1:0] vs2,
                       input logic [ELEM_W-1:0] scalar, input int hold,
                       output logic [ELEM_W-1:0] data, output logic err);
    req_valid  = 1'b1;
    req_op     = op;
    req_vd     = vd;
    req_vs1    = vs1;
    req_vs2    = vs2;
    req_scalar = scalar;
    while (!req_ready) next_cycle();
    next_cycle();
    req_valid = 1'b0;
    while (!resp_valid) next_cycle();
    data = resp_data;
    err  = resp_err;
    repeat (hold) begin
      next_cycle();
      check_val(resp_valid, 1'b1, "resp_valid dropped under back-pressure");
      check_val(resp_data, data, "resp_data changed under back-pressure");
      check_val(resp_err, err, "resp_err changed under back-pressure");
      check_val(req_ready, 1'b0, "req_ready high while a response waits");
    end
    resp_ready = 1'b1;
    next_cycle();
    resp_ready = 1'b0;
  endtask

  // Issue, compare with the model, then update the model
  task automatic do_op(input vec_op_e op, input logic [VREG_IDX_W-1:0] vd,
                       input logic [VREG_IDX_W-1:0] vs1, input logic [VREG_IDX_W-1:0] vs2,
                       input logic [ELEM_W-1:0] scalar, input int hold);
    logic [ELEM_W-1:0] exp_data;
    logic              exp_err;
    logic [ELEM_W-1:0] got_data;
    logic              got_err;
    logic [ELEM_W-1:0] a;
    logic [ELEM_W-1:0] b;
    exp_data = '0;
    exp_err  = 1'b0;
    case (op)
      VSETVL: exp_data = (scalar > VLMAX) ? ELEM_W'(VLMAX) : scalar;
      VEXT_X_V: begin
        if (scalar >= VLMAX) exp_err = 1'b1;
        else exp_data = model_vrf[vs2][scalar];
      end
      VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV, VADD_VX, VMV_V_X, VID_V: exp_data = '0;
      default: exp_err = 1'b1;
    endcase
    issue(op, vd, vs1, vs2, scalar, hold, got_data, got_err);
    check_val(got_data, exp_data, $sformatf("data of op %0h scalar %0d", op, scalar));
    check_val(got_err, exp_err, $sformatf("err of op %0h scalar %0d", op, scalar));
    if (op == VSETVL) model_vl = exp_data;
    // Element e only depends on element e of its sources
    for (int e = 0; e < model_vl; e++) begin
      a = model_vrf[vs2][e];
      b = model_vrf[vs1][e];
      case (op)
        VADD_VV: model_vrf[vd][e] = a + b;
        VSUB_VV: model_vrf[vd][e] = a - b;
        VAND_VV: model_vrf[vd][e] = a & b;
        VOR_VV:  model_vrf[vd][e] = a | b;
        VXOR_VV: model_vrf[vd][e] = a ^ b;
        VADD_VX: model_vrf[vd][e] = a + scalar;
        VMV_V_X: model_vrf[vd][e] = scalar;
        VID_V:   model_vrf[vd][e] = e;
        default: ;
      endcase
    end
  endtask

  task automatic check_reg(input logic [VREG_IDX_W-1:0] vreg);
    for (int e = 0; e < VLMAX; e++) begin
      do_op(VEXT_X_V, '0, '0, vreg, e, 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_vsetvl();
    check_val(req_ready, 1'b1, "req_ready after reset");
    check_val(resp_valid, 1'b0, "resp_valid after reset");
    do_op(VSETVL, 0, 0, 0, 20, 0);
    do_op(VSETVL, 0, 0, 0, 5, 0);
  endtask

  task automatic test_fill_extract();
    do_op(VSETVL, 0, 0, 0, VLMAX, 0);
    do_op(VMV_V_X, 1, 0, 0, next_rand(), 0);
    do_op(VID_V, 2, 0, 0, 0, 0);
    check_reg(1);
    check_reg(2);
  endtask

  task automatic test_alu_ops();
    do_op(VMV_V_X, 3, 0, 0, next_rand(), 0);
    do_op(VID_V, 4, 0, 0, 0, 0);
    do_op(VADD_VX, 4, 0, 4, next_rand(), 0);
    do_op(VADD_VX, 5, 0, 2, next_rand(), 0);
    do_op(VADD_VV, 6, 3, 4, 0, 0);
    do_op(VSUB_VV, 7, 5, 4, 0, 0);
    do_op(VAND_VV, 1, 4, 5, 0, 0);
    do_op(VOR_VV, 2, 3, 5, 0, 0);
    // Destination equals vs1
    do_op(VXOR_VV, 5, 5, 4, 0, 0);
    for (int v = 1; v < NR_VREGS; v++) begin
      check_reg(v);
    end
  endtask

  task automatic test_partial_vl();
    do_op(VSETVL, 0, 0, 0, 5, 0);
    // New values below vl, old values above
    do_op(VADD_VX, 6, 0, 6, next_rand(), 0);
    check_reg(6);
    do_op(VSETVL, 0, 0, 0, 0, 0);
    do_op(VMV_V_X, 7, 0, 0, next_rand(), 0);
    check_reg(7);
  endtask

  task automatic test_backpressure_errors();
    do_op(VSETVL, 0, 0, 0, VLMAX, 0);
    do_op(VEXT_X_V, 0, 0, 4, 9, 6);
    do_op(VMV_V_X, 3, 0, 0, next_rand(), 6);
    do_op(vec_op_e'(4'hc), 1, 2, 3, 7, 0);
    do_op(VEXT_X_V, 0, 0, 4, VLMAX, 0);
    do_op(VADD_VX, 2, 0, 3, next_rand(), 0);
    check_reg(2);
  endtask

  initial begin
    lcg_state  = 32'h9fa1;
    model_vl   = 0;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_op     = VSETVL;
    req_vd     = '0;
    req_vs1    = '0;
    req_vs2    = '0;
    req_scalar = '0;
    resp_ready = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    next_cycle();
    test_reset_vsetvl();
    test_fill_extract();
    test_alu_ops();
    test_partial_vl();
    test_backpressure_errors();
    $display("All tests passed");
    $finish;
  end

endmodule

/* vec_unit.f */
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_beat_counter.sv
source/vec_lane.sv
source/vec_unit.sv
tb/vec_unit_props.sv
tb/vec_unit_tb.sv
